// File: design/cmd_settings.svh
`ifndef CMD_SETTINGS_SVH
`define CMD_SETTINGS_SVH

// ========================================================================
// command word layout
// ========================================================================
`define CMD_WORD_W        16
`define CMD_OPCODE_W      8
`define CMD_ARG1_W        3
`define CMD_ARG2_W        5
`define CMD_IMM_W         8

// ========================================================================
// storage sizes
// ========================================================================
`define CMD_QUEUE_DEPTH   4
`define CMD_REG_COUNT     8
`define CMD_REG_W         8
`define CMD_COUNT_W       8

// limit applied to SET values after reset
`define CMD_DEFAULT_LIMIT 10

`endif

// File: design/cmd_format_pkg.sv
`include "cmd_settings.svh"

package cmd_format_pkg;

        typedef enum logic [`CMD_OPCODE_W-1:0] {
                SET   = 0,
                INC   = 1,
                ADD   = 2,
                CLEAR = 3,
                LIMIT = 4
        } opcode_e;

        // register view: opcode, register index, small value
        typedef struct packed {
                logic [`CMD_OPCODE_W-1:0] opcode;
                logic [`CMD_ARG1_W-1:0]   arg1;
                logic [`CMD_ARG2_W-1:0]   arg2;
        } cmd_fields_t;

        // immediate view, used by LIMIT
        typedef struct packed {
                logic [`CMD_OPCODE_W-1:0] opcode;
                logic [`CMD_IMM_W-1:0]    imm;
        } cmd_imm_t;

        typedef union packed {
                cmd_fields_t fields;
                cmd_imm_t    immed;
        } cmd_word_u;

endpackage

// File: design/cmd_status_pkg.sv
package cmd_status_pkg;

        // outcome of one decoded command
        typedef enum logic [1:0] {
                OK         = 2'd0,
                BAD_OPCODE = 2'd1,
                RANGE      = 2'd2
        } status_e;

endpackage

// File: design/cmd_queue.sv
`include "cmd_settings.svh"

module cmd_queue (
        input  logic                   clk,
        input  logic                   reset,
        input  logic                   push,
        input  logic [`CMD_WORD_W-1:0] word,
        input  logic                   pop,
        output logic [`CMD_WORD_W-1:0] head,
        output logic                   empty,
        output logic                   full
);

        localparam int DEPTH = `CMD_QUEUE_DEPTH;
        localparam int PTR_W = $clog2(DEPTH);
        localparam int CNT_W = $clog2(DEPTH + 1);

        logic [`CMD_WORD_W-1:0] mem [DEPTH];
        logic [PTR_W-1:0]       wr_ptr;
        logic [PTR_W-1:0]       rd_ptr;
        logic [CNT_W-1:0]       count;
        logic                   do_push;
        logic                   do_pop;

        // pushes into a full queue are lost
        assign do_push = push && !full;
        assign do_pop  = pop && !empty;

        assign empty = (count == '0);
        assign full  = (count == CNT_W'(DEPTH));
        assign head  = mem[rd_ptr];

        always_ff @(posedge clk) begin
                if (do_push) begin
                        mem[wr_ptr] <= word;
                end
        end

        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (do_push) begin
                                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                        end
                        if (do_pop) begin
                                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                        end
                        case ({do_push, do_pop})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

endmodule

// File: design/cmd_decoder.sv
`include "cmd_settings.svh"

module cmd_decoder (
        input  logic                      clk,
        input  logic                      reset,
        input  logic                      start,
        input  cmd_format_pkg::cmd_word_u head,
        input  logic                      empty,
        input  logic [`CMD_REG_W-1:0]     limit,
        output logic                      pop,
        output logic                      busy,
        output logic                      done,
        output cmd_status_pkg::status_e   status,
        output cmd_format_pkg::opcode_e   opcode,
        output logic [`CMD_ARG1_W-1:0]    arg1,
        output logic [`CMD_ARG2_W-1:0]    arg2,
        output logic [`CMD_IMM_W-1:0]     imm
);

        typedef enum logic [1:0] {
                IDLE  = 2'd0,
                FETCH = 2'd1,
                CHECK = 2'd2,
                DONE  = 2'd3
        } state_e;

        state_e                    state;
        state_e                    state_next;
        cmd_format_pkg::cmd_word_u word;
        cmd_status_pkg::status_e   chk_status;
        logic [`CMD_ARG2_W-1:0]    chk_arg2;
        logic [`CMD_REG_W-1:0]     set_value;

        // ====================================================================
        // state sequence
        // ====================================================================
        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        state <= IDLE;
                end else begin
                        state <= state_next;
                end
        end

        always_comb begin
                state_next = state;
                case (state)
                        IDLE:    if (start) state_next = FETCH;
                        FETCH:   if (!empty) state_next = CHECK;
                        CHECK:   state_next = DONE;
                        DONE:    state_next = IDLE;
                        default: state_next = IDLE;
                endcase
        end

        assign pop  = (state == FETCH) && !empty;
        assign busy = (state != IDLE);
        assign done = (state == DONE);

        // the head word is taken in the same cycle as pop
        always_ff @(posedge clk) begin
                if (pop) begin
                        word <= head;
                end
        end

        // ====================================================================
        // validation
        // ====================================================================
        assign set_value = {{(`CMD_REG_W - `CMD_ARG2_W){1'b0}}, word.fields.arg2};

        always_comb begin
                chk_status = cmd_status_pkg::OK;
                chk_arg2   = word.fields.arg2;
                if (word.fields.opcode > cmd_format_pkg::LIMIT) begin
                        chk_status = cmd_status_pkg::BAD_OPCODE;
                end else if (word.fields.opcode == cmd_format_pkg::SET) begin
                        if (set_value > limit) begin
                                chk_status = cmd_status_pkg::RANGE;
                        end
                end else if (word.fields.opcode == cmd_format_pkg::INC) begin
                        // INC becomes an add of one in the bank
                        chk_arg2 = `CMD_ARG2_W'(1);
                end
        end

        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        status <= cmd_status_pkg::OK;
                end else if (state == CHECK) begin
                        status <= chk_status;
                end
        end

        always_ff @(posedge clk) begin
                if (state == CHECK) begin
                        opcode <= cmd_format_pkg::opcode_e'(word.fields.opcode);
                        arg1   <= word.fields.arg1;
                        arg2   <= chk_arg2;
                        imm    <= word.immed.imm;
                end
        end

endmodule

// File: design/cmd_config_stats.sv
`include "cmd_settings.svh"

module cmd_config_stats (
        input  logic                    clk,
        input  logic                    reset,
        input  logic                    done,
        input  cmd_status_pkg::status_e status,
        input  cmd_format_pkg::opcode_e opcode,
        input  logic [`CMD_IMM_W-1:0]   imm,
        output logic [`CMD_REG_W-1:0]   limit,
        output logic [`CMD_COUNT_W-1:0] accept_count,
        output logic [`CMD_COUNT_W-1:0] error_count
);

        logic accepted;
        logic rejected;

        assign accepted = done && (status == cmd_status_pkg::OK);
        assign rejected = done && (status != cmd_status_pkg::OK);

        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        limit <= `CMD_REG_W'(`CMD_DEFAULT_LIMIT);
                end else if (accepted && opcode == cmd_format_pkg::LIMIT) begin
                        limit <= imm;
                end
        end

        // both counters stick at all ones
        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        accept_count <= '0;
                        error_count  <= '0;
                end else begin
                        if (accepted && accept_count != '1) begin
                                accept_count <= accept_count + 1'b1;
                        end
                        if (rejected && error_count != '1) begin
                                error_count <= error_count + 1'b1;
                        end
                end
        end

endmodule

// File: design/reg_bank.sv
`include "cmd_settings.svh"

module reg_bank (
        input  logic                    clk,
        input  logic                    reset,
        input  logic                    done,
        input  cmd_status_pkg::status_e status,
        input  cmd_format_pkg::opcode_e opcode,
        input  logic [`CMD_ARG1_W-1:0]  arg1,
        input  logic [`CMD_ARG2_W-1:0]  arg2,
        input  logic [`CMD_ARG1_W-1:0]  rd_addr,
        output logic [`CMD_REG_W-1:0]   rd_data
);

        logic [`CMD_REG_W-1:0] regs [`CMD_REG_COUNT];
        logic [`CMD_REG_W-1:0] value;
        logic                  apply;

        assign value = {{(`CMD_REG_W - `CMD_ARG2_W){1'b0}}, arg2};
        assign apply = done && (status == cmd_status_pkg::OK);

        assign rd_data = regs[rd_addr];

        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        for (int i = 0; i < `CMD_REG_COUNT; i++) begin
                                regs[i] <= '0;
                        end
                end else if (apply) begin
                        case (opcode)
                                cmd_format_pkg::SET: begin
                                        regs[arg1] <= value;
                                end
                                // INC arrives with arg2 already set to one
                                cmd_format_pkg::INC,
                                cmd_format_pkg::ADD: begin
                                        regs[arg1] <= regs[arg1] + value;
                                end
                                cmd_format_pkg::CLEAR: begin
                                        regs[arg1] <= '0;
                                end
                                default: begin
                                        regs[arg1] <= regs[arg1];
                                end
                        endcase
                end
        end

endmodule

// File: design/command_unit.sv
`include "cmd_settings.svh"

module command_unit (
        input  logic                    clk,
        input  logic                    reset,
        input  logic                    cmd_push,
        input  logic [`CMD_WORD_W-1:0]  cmd_word,
        input  logic                    start,
        input  logic [`CMD_ARG1_W-1:0]  rd_addr,
        output logic                    cmd_full,
        output logic                    busy,
        output logic                    done,
        output cmd_status_pkg::status_e status,
        output logic [`CMD_REG_W-1:0]   rd_data,
        output logic [`CMD_REG_W-1:0]   limit,
        output logic [`CMD_COUNT_W-1:0] accept_count,
        output logic [`CMD_COUNT_W-1:0] error_count
);

        logic [`CMD_WORD_W-1:0]  q_head;
        logic                    q_empty;
        logic                    pop;
        cmd_format_pkg::opcode_e opcode;
        logic [`CMD_ARG1_W-1:0]  arg1;
        logic [`CMD_ARG2_W-1:0]  arg2;
        logic [`CMD_IMM_W-1:0]   imm;

        cmd_queue u_queue (
                .clk   (clk),
                .reset (reset),
                .push  (cmd_push),
                .word  (cmd_word),
                .pop   (pop),
                .head  (q_head),
                .empty (q_empty),
                .full  (cmd_full)
        );

        cmd_decoder u_decoder (
                .clk    (clk),
                .reset  (reset),
                .start  (start),
                .head   (q_head),
                .empty  (q_empty),
                .limit  (limit),
                .pop    (pop),
                .busy   (busy),
                .done   (done),
                .status (status),
                .opcode (opcode),
                .arg1   (arg1),
                .arg2   (arg2),
                .imm    (imm)
        );

        cmd_config_stats u_config (
                .clk          (clk),
                .reset        (reset),
                .done         (done),
                .status       (status),
                .opcode       (opcode),
                .imm          (imm),
                .limit        (limit),
                .accept_count (accept_count),
                .error_count  (error_count)
        );

        reg_bank u_bank (
                .clk     (clk),
                .reset   (reset),
                .done    (done),
                .status  (status),
                .opcode  (opcode),
                .arg1    (arg1),
                .arg2    (arg2),
                .rd_addr (rd_addr),
                .rd_data (rd_data)
        );

endmodule

// File: tb/command_unit_sva.sv
module command_unit_sva (
        input logic clk,
        input logic reset,
        input logic start,
        input logic empty,
        input logic pop,
        input logic busy,
        input logic done
);

        timeunit 1ns;
        timeprecision 1ps;

        done_one_cycle: assert property (@(posedge clk) disable iff (!reset)
                done |=> !done)
                else $error("done stayed high for more than one cycle");

        // a pop takes a real word and leads to done through the check cycle
        pop_not_empty: assert property (@(posedge clk) disable iff (!reset)
                pop |-> !empty ##2 done)
                else $error("pop issued while empty or not followed by done");

        // busy covers fetch, check and done
        done_while_busy: assert property (@(posedge clk) disable iff (!reset)
                done |-> busy && $past(busy) && $past(busy, 2))
                else $error("done seen without busy held since fetch");

        // idle decoder with a queued word finishes in a fixed time
        start_to_done: assert property (@(posedge clk) disable iff (!reset)
                start && !busy && !empty |-> ##3 done)
                else $error("done did not follow start after three cycles");

endmodule

bind cmd_decoder command_unit_sva u_sva (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .empty (empty),
        .pop   (pop),
        .busy  (busy),
        .done  (done)
);

// File: tb/command_unit_tb.sv
module command_unit_tb;

        timeunit 1ns;
        timeprecision 1ps;

        localparam int QUEUE_DEPTH = 4;
        localparam int DONE_TIMEOUT = 50;

        localparam logic [7:0] op_set   = 8'd0;
        localparam logic [7:0] op_inc   = 8'd1;
        localparam logic [7:0] op_add   = 8'd2;
        localparam logic [7:0] op_clear = 8'd3;
        localparam logic [7:0] op_limit = 8'd4;

        localparam logic [1:0] st_ok    = 2'd0;
        localparam logic [1:0] st_bad   = 2'd1;
        localparam logic [1:0] st_range = 2'd2;

        logic        clk;
        logic        reset;
        logic        cmd_push;
        logic [15:0] cmd_word;
        logic        start;
        logic [2:0]  rd_addr;
        logic        cmd_full;
        logic        busy;
        logic        done;
        logic [1:0]  status;
        logic [7:0]  rd_data;
        logic [7:0]  limit;
        logic [7:0]  accept_count;
        logic [7:0]  error_count;

        // reference model
        logic [7:0]  model_regs [8];
        logic [7:0]  model_limit;
        logic [7:0]  model_acc;
        logic [7:0]  model_err;
        logic [15:0] model_q [$];

        integer seed;
        int     errors;
        int     test_start_errors;
        int     pass_count;
        int     fail_count;

        command_unit uut (
                .clk          (clk),
                .reset        (reset),
                .cmd_push     (cmd_push),
                .cmd_word     (cmd_word),
                .start        (start),
                .rd_addr      (rd_addr),
                .cmd_full     (cmd_full),
                .busy         (busy),
                .done         (done),
                .status       (status),
                .rd_data      (rd_data),
                .limit        (limit),
                .accept_count (accept_count),
                .error_count  (error_count)
        );

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        // ====================================================================
        // helpers
        // ====================================================================
        function automatic logic [15:0] reg_cmd(input logic [7:0] op, input logic [2:0] a1,
                                                input logic [4:0] a2);
                return {op, a1, a2};
        endfunction

        function automatic logic [15:0] imm_cmd(input logic [7:0] op, input logic [7:0] value);
                return {op, value};
        endfunction

        task automatic report_mismatch(input string name, input logic [15:0] exp,
                                       input logic [15:0] act);
                $display("** Error: %s expected 0x%0h, actual 0x%0h", name, exp, act);
                errors++;
        endtask

        task automatic begin_test();
                test_start_errors = errors;
        endtask

        task automatic end_test(input string name);
                if (errors == test_start_errors) begin
                        pass_count++;
                        $display("%s: pass", name);
                end else begin
                        fail_count++;
                        $display("%s: fail with %0d errors", name, errors - test_start_errors);
                end
        endtask

        // applies one word to the model and gives the status it should produce
        task automatic apply_model(input logic [15:0] w, output logic [1:0] exp);
                logic [7:0] op;
                logic [2:0] a1;
                logic [4:0] a2;
                op = w[15:8];
                a1 = w[7:5];
                a2 = w[4:0];
                if (op > op_limit) begin
                        exp = st_bad;
                end else if (op == op_set && {3'b000, a2} > model_limit) begin
                        exp = st_range;
                end else begin
                        exp = st_ok;
                end
                if (exp == st_ok) begin
                        if (model_acc != 8'hff) begin
                                model_acc = model_acc + 8'd1;
                        end
                        case (op)
                                op_set:   model_regs[a1] = {3'b000, a2};
                                op_inc:   model_regs[a1] = model_regs[a1] + 8'd1;
                                op_add:   model_regs[a1] = model_regs[a1] + {3'b000, a2};
                                op_clear: model_regs[a1] = 8'h00;
                                default:  model_limit = w[7:0];
                        endcase
                end else if (model_err != 8'hff) begin
                        model_err = model_err + 8'd1;
                end
        endtask

        task automatic push_word(input logic [15:0] w);
                if (cmd_full !== (model_q.size() == QUEUE_DEPTH)) begin
                        report_mismatch("cmd_full", 16'(model_q.size() == QUEUE_DEPTH),
                                        16'(cmd_full));
                end
                cmd_push = 1'b1;
                cmd_word = w;
                @(posedge clk);
                #1;
                cmd_push = 1'b0;
                // a push into a full queue is lost
                if (model_q.size() < QUEUE_DEPTH) begin
                        model_q.push_back(w);
                end
        endtask

        task automatic pulse_start();
                start = 1'b1;
                @(posedge clk);
                #1;
                start = 1'b0;
        endtask

        task automatic wait_done(output int lat, output logic arrived);
                lat = 1;
                while (!done && lat < DONE_TIMEOUT) begin
                        @(posedge clk);
                        #1;
                        lat++;
                end
                arrived = done;
                if (!arrived) begin
                        $display("timeout: done did not arrive within %0d cycles", DONE_TIMEOUT);
                        errors++;
                end
        endtask

        // called in the done cycle, returns one cycle later
        task automatic finish_cmd();
                logic [15:0] w;
                logic [1:0]  exp;
                if (model_q.size() == 0) begin
                        $display("done arrived although the model holds no queued word");
                        errors++;
                end else begin
                        w = model_q.pop_front();
                        apply_model(w, exp);
                        if (status !== exp) begin
                                report_mismatch("status", 16'(exp), 16'(status));
                        end
                        @(posedge clk);
                        #1;
                        if (busy !== 1'b0) begin
                                report_mismatch("busy", 16'h0, 16'(busy));
                        end
                        if (limit !== model_limit) begin
                                report_mismatch("limit", 16'(model_limit), 16'(limit));
                        end
                        if (accept_count !== model_acc) begin
                                report_mismatch("accept_count", 16'(model_acc), 16'(accept_count));
                        end
                        if (error_count !== model_err) begin
                                report_mismatch("error_count", 16'(model_err), 16'(error_count));
                        end
                end
        endtask

        task automatic run_cmd();
                int   lat;
                logic arrived;
                pulse_start();
                wait_done(lat, arrived);
                if (arrived) begin
                        if (lat != 3) begin
                                $display("done arrived %0d cycles after start instead of 3", lat);
                                errors++;
                        end
                        finish_cmd();
                end
        endtask

        task automatic check_reg(input logic [2:0] addr, input logic [7:0] exp);
                rd_addr = addr;
                @(posedge clk);
                #1;
                if (rd_data !== exp) begin
                        report_mismatch($sformatf("rd_data[%0d]", addr), 16'(exp), 16'(rd_data));
                end
        endtask

        task automatic check_bank();
                for (int i = 0; i < 8; i++) begin
                        check_reg(3'(i), model_regs[i]);
                end
        endtask

        // ====================================================================
        // tests
        // ====================================================================
        task automatic check_reset_state();
                begin_test();
                if (busy !== 1'b0) begin
                        report_mismatch("busy", 16'h0, 16'(busy));
                end
                if (done !== 1'b0) begin
                        report_mismatch("done", 16'h0, 16'(done));
                end
                if (status !== st_ok) begin
                        report_mismatch("status", 16'(st_ok), 16'(status));
                end
                if (limit !== 8'h0a) begin
                        report_mismatch("limit", 16'h000a, 16'(limit));
                end
                if (accept_count !== 8'h00) begin
                        report_mismatch("accept_count", 16'h0, 16'(accept_count));
                end
                if (error_count !== 8'h00) begin
                        report_mismatch("error_count", 16'h0, 16'(error_count));
                end
                check_bank();
                end_test("reset state");
        endtask

        task automatic apply_accepted_cmds();
                logic [2:0] r0;
                logic [2:0] r1;
                logic [4:0] v;
                begin_test();
                r0 = 3'($unsigned($random(seed)));
                r1 = 3'($unsigned($random(seed)));
                v = 5'($unsigned($random(seed)) % 11);
                push_word(reg_cmd(op_set, r0, v));
                run_cmd();
                push_word(reg_cmd(op_inc, r0, 5'd0));
                run_cmd();
                push_word(reg_cmd(op_add, r0, 5'd7));
                run_cmd();
                check_reg(r0, model_regs[r0]);
                push_word(reg_cmd(op_clear, r0, 5'd0));
                run_cmd();
                // 10 plus eight adds of 31 wraps past 255
                push_word(reg_cmd(op_set, r1, 5'd10));
                run_cmd();
                for (int i = 0; i < 8; i++) begin
                        push_word(reg_cmd(op_add, r1, 5'd31));
                        run_cmd();
                end
                check_bank();
                end_test("accepted commands");
        endtask

        task automatic reject_bad_cmds();
                logic [7:0] op;
                logic [4:0] v;
                begin_test();
                op = 8'(5 + ($unsigned($random(seed)) % 251));
                push_word(reg_cmd(op, 3'd2, 5'd3));
                run_cmd();
                v = 5'(11 + ($unsigned($random(seed)) % 21));
                push_word(reg_cmd(op_set, 3'($unsigned($random(seed))), v));
                run_cmd();
                check_bank();
                end_test("rejections");
        endtask

        task automatic program_limit();
                begin_test();
                push_word(reg_cmd(op_set, 3'd4, 5'd20));
                run_cmd();
                push_word(imm_cmd(op_limit, 8'h1f));
                run_cmd();
                push_word(reg_cmd(op_set, 3'd4, 5'd20));
                run_cmd();
                push_word(imm_cmd(op_limit, 8'h03));
                run_cmd();
                push_word(reg_cmd(op_set, 3'd1, 5'd5));
                run_cmd();
                check_bank();
                end_test("limit");
        endtask

        task automatic exercise_queue();
                int   lat;
                logic arrived;
                begin_test();
                push_word(reg_cmd(op_set, 3'd2, 5'd3));
                push_word(reg_cmd(op_inc, 3'd2, 5'd0));
                push_word(reg_cmd(op_set, 3'd5, 5'd2));
                push_word(reg_cmd(op_add, 3'd2, 5'd9));
                // fifth word meets a full queue
                push_word(reg_cmd(op_clear, 3'd2, 5'd0));
                for (int i = 0; i < QUEUE_DEPTH; i++) begin
                        run_cmd();
                end
                check_bank();
                pulse_start();
                for (int i = 0; i < 5; i++) begin
                        if (busy !== 1'b1) begin
                                report_mismatch("busy", 16'h1, 16'(busy));
                        end
                        if (done !== 1'b0) begin
                                report_mismatch("done", 16'h0, 16'(done));
                        end
                        @(posedge clk);
                        #1;
                end
                push_word(reg_cmd(op_inc, 3'd6, 5'd0));
                wait_done(lat, arrived);
                if (arrived) begin
                        finish_cmd();
                end
                check_bank();
                end_test("queue");
        endtask

        // ====================================================================
        // main sequence
        // ====================================================================
        initial begin
                reset = 1'b0;
                cmd_push = 1'b0;
                cmd_word = 16'h0000;
                start = 1'b0;
                rd_addr = 3'd0;
                seed = 89793;
                errors = 0;
                test_start_errors = 0;
                pass_count = 0;
                fail_count = 0;
                for (int i = 0; i < 8; i++) begin
                        model_regs[i] = 8'h00;
                end
                model_limit = 8'h0a;
                model_acc = 8'h00;
                model_err = 8'h00;
                repeat (2) @(posedge clk);
                #1;
                reset = 1'b1;

                check_reset_state();
                apply_accepted_cmds();
                reject_bad_cmds();
                program_limit();
                exercise_queue();

                $display("summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
                if (errors == 0 && fail_count == 0) begin
                        $display("TESTS PASSED");
                end else begin
                        $display("TESTS FAILED");
                end
                $finish;
        end

endmodule

// File: sources.f
+incdir+design
design/cmd_format_pkg.sv
design/cmd_status_pkg.sv
design/cmd_queue.sv
design/cmd_decoder.sv
design/cmd_config_stats.sv
design/reg_bank.sv
design/command_unit.sv
tb/command_unit_sva.sv
tb/command_unit_tb.sv

// File: run.sh
#!/bin/sh
# build and run the command unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module command_unit_tb -f sources.f -o sim_cmd
if [ $? -ne 0 ]; then
        echo "verilator build failed"
        exit 1
fi

./obj_dir/sim_cmd > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
        echo "simulation exited with status $run_status"
        exit 1
fi

if grep -q "TESTS PASSED" "$log"; then
        exit 0
fi
exit 1
